// File: rtl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Data word and general register width.
`define MIPS_REG_W 32
// Register address width.
`define MIPS_REG_ADDR_W 5
// Number of general registers.
`define MIPS_REG_COUNT 32
// Immediate field width.
`define MIPS_IMM_W 16

`endif

// File: rtl/mips_isa_pkg.sv
`include "mips_settings.svh"

package mips_isa_pkg;

	localparam logic [5:0] OP_SPECIAL = 6'b000000;	// R-type, decoded by funct.
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;

	localparam logic [5:0] FN_SLL  = 6'b000000;	// Shift by shamt.
	localparam logic [5:0] FN_SRL  = 6'b000010;
	localparam logic [5:0] FN_SRA  = 6'b000011;
	localparam logic [5:0] FN_SLLV = 6'b000100;	// Shift by rs.
	localparam logic [5:0] FN_SRLV = 6'b000110;
	localparam logic [5:0] FN_SRAV = 6'b000111;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_NOR  = 6'b100111;

	typedef struct packed
	{
		logic [5:0]                  opcode;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [`MIPS_REG_ADDR_W-1:0] rd;
		logic [4:0]                  shamt;
		logic [5:0]                  funct;
	} inst_r_t;

	typedef struct packed
	{
		logic [5:0]                  opcode;
		logic [`MIPS_REG_ADDR_W-1:0] rs;
		logic [`MIPS_REG_ADDR_W-1:0] rt;
		logic [`MIPS_IMM_W-1:0]      imm;
	} inst_i_t;

	// One instruction word, read as R-type or I-type.
	typedef union packed
	{
		inst_r_t r;
		inst_i_t i;
	} inst_u;

endpackage

// File: rtl/mips_pipe_pkg.sv
package mips_pipe_pkg;

	// Operation carried from decode into execute.
	typedef enum logic [3:0]
	{
		NOP = 4'd0,
		AND = 4'd1,
		OR  = 4'd2,
		XOR = 4'd3,
		NOR = 4'd4,
		SLL = 4'd5,
		SRL = 4'd6,
		SRA = 4'd7
	} aluop_e;

	// Which unit supplies the result.
	typedef enum logic [1:0]
	{
		RES_NOP   = 2'd0,
		RES_LOGIC = 2'd1,
		RES_SHIFT = 2'd2
	} alusel_e;

endpackage

// File: rtl/mips_ifs.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

// Decoded operation registered by decode, consumed by execute.
interface id_ex_if;
	import mips_pipe_pkg::*;

	aluop_e                      aluop;
	alusel_e                     alusel;
	logic [`MIPS_REG_W-1:0]      reg1;	// Source operand 1.
	logic [`MIPS_REG_W-1:0]      reg2;	// Source operand 2.
	logic [`MIPS_REG_ADDR_W-1:0] wd;	// Destination register.
	logic                        wreg;	// Low for a bubble.

	modport producer
	(
		output aluop, alusel, reg1, reg2, wd, wreg
	);

	modport consumer
	(
		input aluop, alusel, reg1, reg2, wd, wreg
	);
endinterface

// Results still in flight, fed back to the operand selection in decode.
interface fwd_if;
	logic                        ex_wreg;	// Execute stage, combinational.
	logic [`MIPS_REG_ADDR_W-1:0] ex_wd;
	logic [`MIPS_REG_W-1:0]      ex_wdata;
	logic                        wb_wreg;	// Write-back stage, registered.
	logic [`MIPS_REG_ADDR_W-1:0] wb_wd;
	logic [`MIPS_REG_W-1:0]      wb_wdata;

	modport producer
	(
		output ex_wreg, ex_wd, ex_wdata, wb_wreg, wb_wd, wb_wdata
	);

	modport consumer
	(
		input ex_wreg, ex_wd, ex_wdata, wb_wreg, wb_wd, wb_wdata
	);
endinterface

// File: rtl/regfile.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module regfile
(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        we_i,
	input  logic [`MIPS_REG_ADDR_W-1:0] waddr_i,
	input  logic [`MIPS_REG_W-1:0]      wdata_i,
	input  logic [`MIPS_REG_ADDR_W-1:0] raddr1_i,
	input  logic [`MIPS_REG_ADDR_W-1:0] raddr2_i,
	output logic [`MIPS_REG_W-1:0]      rdata1_o,
	output logic [`MIPS_REG_W-1:0]      rdata2_o
);
	logic [`MIPS_REG_W-1:0] regs [`MIPS_REG_COUNT];

	// Same-cycle write wins over the stored value.
	function automatic logic [`MIPS_REG_W-1:0] read_port(input logic [`MIPS_REG_ADDR_W-1:0] raddr);
		if (we_i && (waddr_i == raddr) && (waddr_i != '0))
			return wdata_i;
		return regs[raddr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int k = 0; k < `MIPS_REG_COUNT; k++)
				regs[k] <= '0;
		end
		else if (we_i && (waddr_i != '0))	// r0 stays zero.
			regs[waddr_i] <= wdata_i;
	end

	always_comb
	begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end
endmodule

// File: rtl/id_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module id_stage
(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        inst_valid_i,
	input  mips_isa_pkg::inst_u         inst_i,
	output logic [`MIPS_REG_ADDR_W-1:0] raddr1_o,
	output logic [`MIPS_REG_ADDR_W-1:0] raddr2_o,
	input  logic [`MIPS_REG_W-1:0]      rdata1_i,
	input  logic [`MIPS_REG_W-1:0]      rdata2_i,
	fwd_if.consumer                     fwd,
	id_ex_if.producer                   ex_o
);
	import mips_isa_pkg::*;
	import mips_pipe_pkg::*;

	aluop_e                      aluop;
	alusel_e                     alusel;
	logic                        re1;	// Operand 1 comes from rs.
	logic                        re2;	// Operand 2 comes from rt.
	logic                        wreg;
	logic [`MIPS_REG_ADDR_W-1:0] wd;
	logic [`MIPS_REG_W-1:0]      imm;
	logic [`MIPS_REG_W-1:0]      imm_zx;
	logic [`MIPS_REG_W-1:0]      op1;
	logic [`MIPS_REG_W-1:0]      op2;

	// Execute result first, then write-back, then the regfile.
	function automatic logic [`MIPS_REG_W-1:0] pick_operand(
		input logic                        re,
		input logic [`MIPS_REG_ADDR_W-1:0] addr,
		input logic [`MIPS_REG_W-1:0]      rdata,
		input logic [`MIPS_REG_W-1:0]      immv
	);
		if (!re)
			return immv;
		if (fwd.ex_wreg && (fwd.ex_wd == addr))
			return fwd.ex_wdata;
		if (fwd.wb_wreg && (fwd.wb_wd == addr))
			return fwd.wb_wdata;
		return rdata;
	endfunction

	assign imm_zx   = {{(`MIPS_REG_W-`MIPS_IMM_W){1'b0}}, inst_i.i.imm};
	assign raddr1_o = inst_i.r.rs;
	assign raddr2_o = inst_i.r.rt;

	always_comb
	begin
		aluop = NOP;
		re1   = 1'b0;
		re2   = 1'b0;
		wd    = inst_i.i.rt;	// I-type writes rt.
		imm   = imm_zx;
		case (inst_i.r.opcode)
			OP_SPECIAL:
			begin
				re1 = 1'b1;
				re2 = 1'b1;
				wd  = inst_i.r.rd;
				case (inst_i.r.funct)
					FN_AND:  aluop = AND;
					FN_OR:   aluop = OR;
					FN_XOR:  aluop = XOR;
					FN_NOR:  aluop = NOR;
					FN_SLL:  aluop = SLL;
					FN_SRL:  aluop = SRL;
					FN_SRA:  aluop = SRA;
					FN_SLLV: aluop = SLL;
					FN_SRLV: aluop = SRL;
					FN_SRAV: aluop = SRA;
					default: aluop = NOP;
				endcase
				// Constant shifts use shamt as the shift amount.
				if (inst_i.r.funct inside {FN_SLL, FN_SRL, FN_SRA})
				begin
					re1 = 1'b0;
					imm = {{(`MIPS_REG_W-5){1'b0}}, inst_i.r.shamt};
				end
			end
			OP_ANDI:
			begin
				re1   = 1'b1;
				aluop = AND;
			end
			OP_ORI:
			begin
				re1   = 1'b1;
				aluop = OR;
			end
			OP_XORI:
			begin
				re1   = 1'b1;
				aluop = XOR;
			end
			OP_LUI:
			begin
				aluop = OR;	// imm | imm, both operands immediate.
				imm   = {inst_i.i.imm, {(`MIPS_REG_W-`MIPS_IMM_W){1'b0}}};
			end
			default:
				aluop = NOP;
		endcase
	end

	always_comb
	begin
		case (aluop)
			NOP:           alusel = RES_NOP;
			SLL, SRL, SRA: alusel = RES_SHIFT;
			default:       alusel = RES_LOGIC;
		endcase
	end

	// Invalid slot, unknown opcode or r0 target makes a bubble.
	assign wreg = inst_valid_i && (aluop != NOP) && (wd != '0);

	always_comb
	begin
		op1 = pick_operand(re1, inst_i.r.rs, rdata1_i, imm);
		op2 = pick_operand(re2, inst_i.r.rt, rdata2_i, imm);
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ex_o.aluop  <= NOP;
			ex_o.alusel <= RES_NOP;
			ex_o.reg1   <= '0;
			ex_o.reg2   <= '0;
			ex_o.wd     <= '0;
			ex_o.wreg   <= 1'b0;
		end
		else
		begin
			ex_o.aluop  <= aluop;
			ex_o.alusel <= alusel;
			ex_o.reg1   <= op1;
			ex_o.reg2   <= op2;
			ex_o.wd     <= wd;
			ex_o.wreg   <= wreg;
		end
	end
endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module ex_stage
(
	input  logic                        clk,
	input  logic                        rst_i,
	id_ex_if.consumer                   id_i,
	fwd_if.producer                     fwd,
	output logic                        wb_we_o,
	output logic [`MIPS_REG_ADDR_W-1:0] wb_addr_o,
	output logic [`MIPS_REG_W-1:0]      wb_data_o
);
	import mips_pipe_pkg::*;

	localparam int SA_W = $clog2(`MIPS_REG_W);

	logic [SA_W-1:0]        sa;	// Shift amount from operand 1.
	logic [`MIPS_REG_W-1:0] logic_res;
	logic [`MIPS_REG_W-1:0] shift_res;
	logic [`MIPS_REG_W-1:0] result;

	assign sa = id_i.reg1[SA_W-1:0];

	always_comb
	begin
		case (id_i.aluop)
			AND:     logic_res = id_i.reg1 & id_i.reg2;
			OR:      logic_res = id_i.reg1 | id_i.reg2;
			XOR:     logic_res = id_i.reg1 ^ id_i.reg2;
			NOR:     logic_res = ~(id_i.reg1 | id_i.reg2);
			default: logic_res = '0;
		endcase
	end

	always_comb
	begin
		case (id_i.aluop)
			SLL:     shift_res = id_i.reg2 << sa;
			SRL:     shift_res = id_i.reg2 >> sa;
			SRA:     shift_res = $signed(id_i.reg2) >>> sa;	// Sign fill.
			default: shift_res = '0;
		endcase
	end

	always_comb
	begin
		case (id_i.alusel)
			RES_LOGIC: result = logic_res;
			RES_SHIFT: result = shift_res;
			default:   result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			wb_we_o   <= 1'b0;
			wb_addr_o <= '0;
			wb_data_o <= '0;
		end
		else
		begin
			wb_we_o   <= id_i.wreg;
			wb_addr_o <= id_i.wd;
			wb_data_o <= result;
		end
	end

	assign fwd.ex_wreg  = id_i.wreg;
	assign fwd.ex_wd    = id_i.wd;
	assign fwd.ex_wdata = result;
	assign fwd.wb_wreg  = wb_we_o;	// Same word the regfile is writing.
	assign fwd.wb_wd    = wb_addr_o;
	assign fwd.wb_wdata = wb_data_o;
endmodule

// File: rtl/mips_core.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core
(
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic                        inst_valid_i,
	input  logic [31:0]                 inst_i,
	output logic                        wb_we_o,
	output logic [`MIPS_REG_ADDR_W-1:0] wb_addr_o,
	output logic [`MIPS_REG_W-1:0]      wb_data_o
);
	logic [`MIPS_REG_ADDR_W-1:0] raddr1;
	logic [`MIPS_REG_ADDR_W-1:0] raddr2;
	logic [`MIPS_REG_W-1:0]      rdata1;
	logic [`MIPS_REG_W-1:0]      rdata2;

	id_ex_if id_ex ();
	fwd_if   fwd ();

	regfile u_regfile
	(
		.clk      (clk),
		.rst_i    (rst_i),
		.we_i     (wb_we_o),	// Write-back drives the write port.
		.waddr_i  (wb_addr_o),
		.wdata_i  (wb_data_o),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	id_stage u_id_stage
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.raddr1_o     (raddr1),
		.raddr2_o     (raddr2),
		.rdata1_i     (rdata1),
		.rdata2_i     (rdata2),
		.fwd          (fwd.consumer),
		.ex_o         (id_ex.producer)
	);

	ex_stage u_ex_stage
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.id_i      (id_ex.consumer),
		.fwd       (fwd.producer),
		.wb_we_o   (wb_we_o),
		.wb_addr_o (wb_addr_o),
		.wb_data_o (wb_data_o)
	);
endmodule

// File: tests/mips_core_assertions.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core_assertions
(
	input logic                        clk,
	input logic                        rst_i,
	input logic                        inst_valid_i,
	input logic                        wb_we_i,
	input logic [`MIPS_REG_ADDR_W-1:0] wb_addr_i
);
	// Reset clears the EX/WB register.
	reset_quiet: assert property (@(posedge clk) rst_i |=> !wb_we_i)
		else $error("write-back enable high while reset was asserted");

	// The ID/EX bubble left by reset still drains one cycle later.
	after_reset_quiet: assert property (@(posedge clk) $past(rst_i) |=> !wb_we_i)
		else $error("write-back enable high in the cycle after reset");

	// r0 writes are squashed in decode.
	no_r0_write: assert property (@(posedge clk) disable iff (rst_i)
		wb_we_i |-> (wb_addr_i != '0))
		else $error("write-back issued to register zero");

	// Two edges from issue to write-back.
	write_has_issue: assert property (@(posedge clk) disable iff (rst_i)
		wb_we_i |-> $past(inst_valid_i, 2))
		else $error("write-back without a valid instruction two cycles earlier");
endmodule

bind mips_core mips_core_assertions u_assertions
(
	.clk          (clk),
	.rst_i        (rst_i),
	.inst_valid_i (inst_valid_i),
	.wb_we_i      (wb_we_o),
	.wb_addr_i    (wb_addr_o)
);

// File: tests/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_settings.svh"

module mips_core_tb;
	import mips_isa_pkg::*;

	localparam int NUM_RANDOM = 400;
	localparam int DRAIN_LIMIT = 20;
	localparam logic [5:0] FUNCT_TABLE [10] = '{FN_AND, FN_OR, FN_XOR, FN_NOR,
		FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

	logic                        clk;
	logic                        rst_i;
	logic                        inst_valid_i;
	logic [31:0]                 inst_i;
	logic                        wb_we_o;
	logic [`MIPS_REG_ADDR_W-1:0] wb_addr_o;
	logic [`MIPS_REG_W-1:0]      wb_data_o;

	logic [`MIPS_REG_W-1:0]      model_regs [`MIPS_REG_COUNT];
	logic [36:0]                 exp_q [$];	// {addr, data} in issue order.
	logic [36:0]                 got_w;
	logic [31:0]                 rng_state;
	int                          wait_cycles;

	mips_core dut
	(
		.clk          (clk),
		.rst_i        (rst_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.wb_we_o      (wb_we_o),
		.wb_addr_o    (wb_addr_o),
		.wb_data_o    (wb_data_o)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
		return {OP_SPECIAL, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] arith_shift_right(input logic [31:0] v, input logic [4:0] n);
		logic [31:0] fill;
		fill = v[31] ? ~(32'hffff_ffff >> n) : 32'h0;	// Sign bits shifted in.
		return (v >> n) | fill;
	endfunction

	// Returns {we, addr, data} for one instruction against the model state.
	function automatic logic [37:0] ref_result(input logic valid, input logic [31:0] inst);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] zimm;
		logic [4:0]  dest;
		logic        ok;
		a    = model_regs[inst[25:21]];
		b    = model_regs[inst[20:16]];
		zimm = {16'h0, inst[15:0]};
		dest = inst[20:16];
		res  = '0;
		ok   = 1'b1;
		case (inst[31:26])
			OP_SPECIAL:
			begin
				dest = inst[15:11];
				case (inst[5:0])
					FN_AND:  res = a & b;
					FN_OR:   res = a | b;
					FN_XOR:  res = a ^ b;
					FN_NOR:  res = ~(a | b);
					FN_SLL:  res = b << inst[10:6];
					FN_SRL:  res = b >> inst[10:6];
					FN_SRA:  res = arith_shift_right(b, inst[10:6]);
					FN_SLLV: res = b << a[4:0];
					FN_SRLV: res = b >> a[4:0];
					FN_SRAV: res = arith_shift_right(b, a[4:0]);
					default: ok = 1'b0;
				endcase
			end
			OP_ANDI: res = a & zimm;
			OP_ORI:  res = a | zimm;
			OP_XORI: res = a ^ zimm;
			OP_LUI:  res = {inst[15:0], 16'h0};
			default: ok = 1'b0;
		endcase
		return {valid && ok && (dest != '0), dest, res};
	endfunction

	task automatic issue(input logic valid, input logic [31:0] inst);
		logic [37:0] expect_w;
		@(posedge clk);
		#1;
		inst_valid_i = valid;
		inst_i       = inst;
		expect_w     = ref_result(valid, inst);
		if (expect_w[37])
		begin
			exp_q.push_back(expect_w[36:0]);
			model_regs[expect_w[36:32]] = expect_w[31:0];
		end
	endtask

	task automatic issue_random();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [3:0]  fsel;
		logic [31:0] inst;
		next_rand(r);
		next_rand(r2);
		rs   = {2'b00, r[2:0]};	// Few registers, many hazards.
		rt   = {2'b00, r[5:3]};
		rd   = {2'b00, r[8:6]};
		fsel = r[16:13] % 4'd10;
		case (r[11:9])
			3'd0, 3'd1, 3'd2: inst = enc_r(rs, rt, rd, r2[20:16], FUNCT_TABLE[fsel]);
			3'd3:    inst = enc_i(OP_ANDI, rs, rt, r2[15:0]);
			3'd4:    inst = enc_i(OP_ORI, rs, rt, r2[15:0]);
			3'd5:    inst = enc_i(OP_XORI, rs, rt, r2[15:0]);
			3'd6:    inst = enc_i(OP_LUI, rs, rt, r2[15:0]);
			default:
				inst = r[12] ? enc_i(6'h23, rs, rt, r2[15:0])
					: enc_r(rs, rt, rd, 5'd0, 6'h20);
		endcase
		issue(r[20:18] != 3'd0, inst);
	endtask

	// Every write-back must match the oldest expected write.
	always @(posedge clk)
	begin
		if (wb_we_o)
		begin
			assert (exp_q.size() > 0)
			else
				abort_run($sformatf("Write-back to r%0d appeared with no write expected",
					wb_addr_o));
			got_w = exp_q.pop_front();
			assert ({wb_addr_o, wb_data_o} == got_w)
			else
				abort_run($sformatf("[ERROR] %0t: wrote r%0d = %08h, expected r%0d = %08h",
					$time, wb_addr_o, wb_data_o, got_w[36:32], got_w[31:0]));
		end
	end

	initial
	begin
		clk          = 1'b0;
		rst_i        = 1'b1;
		inst_valid_i = 1'b1;	// A live ori during reset must not write.
		inst_i       = enc_i(OP_ORI, 5'd0, 5'd1, 16'h1234);
		rng_state    = 32'hf626;
		for (int k = 0; k < `MIPS_REG_COUNT; k++)
			model_regs[k] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_i        = 1'b0;
		inst_valid_i = 1'b0;

		repeat (3) issue(1'b0, 32'h0);	// Idle, nothing may be written.
		issue(1'b1, enc_i(OP_ORI, 5'd0, 5'd1, 16'h8421));
		issue(1'b1, enc_i(OP_XORI, 5'd0, 5'd2, 16'hf00f));
		issue(1'b1, enc_i(OP_LUI, 5'd0, 5'd3, 16'h9abc));
		issue(1'b1, enc_i(OP_ANDI, 5'd3, 5'd4, 16'hffff));
		issue(1'b1, enc_i(OP_ANDI, 5'd1, 5'd4, 16'h0ff0));
		issue(1'b1, enc_r(5'd1, 5'd2, 5'd5, 5'd0, FN_AND));
		issue(1'b1, enc_r(5'd1, 5'd2, 5'd6, 5'd0, FN_OR));
		issue(1'b1, enc_r(5'd1, 5'd3, 5'd7, 5'd0, FN_XOR));
		issue(1'b1, enc_r(5'd1, 5'd2, 5'd5, 5'd0, FN_NOR));
		issue(1'b1, enc_r(5'd0, 5'd3, 5'd4, 5'd4, FN_SLL));
		issue(1'b1, enc_r(5'd0, 5'd3, 5'd5, 5'd8, FN_SRL));
		issue(1'b1, enc_r(5'd0, 5'd3, 5'd6, 5'd8, FN_SRA));	// Negative source.
		issue(1'b1, enc_i(OP_ORI, 5'd0, 5'd7, 16'h0024));
		issue(1'b1, enc_r(5'd7, 5'd1, 5'd4, 5'd0, FN_SLLV));
		issue(1'b1, enc_r(5'd7, 5'd3, 5'd5, 5'd0, FN_SRLV));
		issue(1'b1, enc_r(5'd7, 5'd3, 5'd6, 5'd0, FN_SRAV));
		issue(1'b1, enc_i(OP_ORI, 5'd0, 5'd1, 16'h0005));	// Hazards at distance 1 to 3.
		issue(1'b1, enc_i(OP_XORI, 5'd1, 5'd2, 16'h0003));
		issue(1'b1, enc_i(OP_ANDI, 5'd1, 5'd3, 16'h0007));
		issue(1'b1, enc_r(5'd1, 5'd2, 5'd4, 5'd0, FN_OR));
		issue(1'b1, enc_r(5'd3, 5'd2, 5'd5, 5'd0, FN_SLLV));
		issue(1'b1, enc_i(6'h23, 5'd1, 5'd2, 16'h0001));	// Unsupported opcode.
		issue(1'b0, enc_i(OP_ORI, 5'd0, 5'd1, 16'hffff));
		issue(1'b1, enc_i(OP_ORI, 5'd1, 5'd0, 16'hffff));
		issue(1'b1, enc_r(5'd0, 5'd1, 5'd6, 5'd0, FN_OR));

		for (int n = 0; n < NUM_RANDOM; n++)
			issue_random();
		issue(1'b0, 32'h0);

		wait_cycles = 0;
		while ((exp_q.size() != 0) && (wait_cycles < DRAIN_LIMIT))
		begin
			@(posedge clk);
			#1;
			wait_cycles++;
		end
		repeat (3) @(posedge clk);	// Catch any stray write.
		#1;
		if (exp_q.size() != 0)
			abort_run($sformatf("Timed out with %0d expected writes missing", exp_q.size()));
		else
		begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end
endmodule

// File: sources.f
+incdir+rtl
rtl/mips_isa_pkg.sv
rtl/mips_pipe_pkg.sv
rtl/mips_ifs.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mips_core.sv
tests/mips_core_assertions.sv
tests/mips_core_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mips_core_tb -f sources.f &&
./obj_dir/Vmips_core_tb ||
{ echo "Simulation did not pass" >&2; exit 1; }
